// File: Makefile
# Verilator build and run for the histogram testbench

VERILATOR  ?= verilator
TOP        ?= hist_tb
RTL_TOP    ?= hist_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= No errors
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
+incdir+hdl
hdl/hist_pkg.sv
hdl/hist_event_sequencer.sv
hdl/hist_bin_accumulator.sv
hdl/hist_axil_readout.sv
hdl/hist_top.sv
verification/hist_tb.sv

// File: hdl/hist_axil_readout.sv
`include "hist_consts.svh"

module hist_axil_readout (
    input  logic                                     clk,
    input  logic                                     combin_res,
    input  logic [`HIST_AXI_ADDR_BITS-1:0]           awaddr,
    input  logic                                     awvalid,
    output logic                                     awready,
    input  logic [31:0]                              wdata,
    input  logic [3:0]                               wstrb,
    input  logic                                     wvalid,
    output logic                                     wready,
    output logic [1:0]                               bresp,
    output logic                                     bvalid,
    input  logic                                     bready,
    input  logic [`HIST_AXI_ADDR_BITS-1:0]           araddr,
    input  logic                                     arvalid,
    output logic                                     arready,
    output logic [31:0]                              rdata,
    output logic [1:0]                               rresp,
    output logic                                     rvalid,
    input  logic                                     rready,
    input  logic                                     done_pulse,
    input  logic                                     held_bank,
    input  logic                                     stalled,
    output logic                                     bank_held,
    output logic                                     rd_en,
    output logic [`HIST_PIX_BITS+`HIST_BIN_BITS-1:0] rd_addr,
    input  logic [`HIST_COUNT_BITS-1:0]              rd_count
);

    localparam int AXI_BITS      = `HIST_AXI_ADDR_BITS;
    localparam int BIN_ADDR_BITS = `HIST_PIX_BITS + `HIST_BIN_BITS;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [AXI_BITS-1:0] BIN_BASE = `HIST_ADDR_BIN_BASE;
    localparam logic [AXI_BITS-1:0] BIN_END  = BIN_BASE + AXI_BITS'(4 << BIN_ADDR_BITS);

    // word match, byte lanes ignored
    function automatic logic addr_is(input logic [AXI_BITS-1:0] addr,
                                     input logic [AXI_BITS-1:0] target);
        return addr[AXI_BITS-1:2] == target[AXI_BITS-1:2];
    endfunction

    function automatic logic addr_is_bin(input logic [AXI_BITS-1:0] addr);
        return (addr >= BIN_BASE) && (addr < BIN_END);
    endfunction

    logic                  ar_hs;
    logic                  aw_hs;
    logic                  rel_write;
    logic                  rd_busy;
    logic                  rd_step1;
    logic                  rd_step2;
    logic                  wr_pend;
    logic [AXI_BITS-1:0]   ar_addr_q;
    logic [AXI_BITS-1:0]   bin_off;
    logic [15:0]           frame_count;
    hist_pkg::hist_status_t status;
    hist_pkg::hist_rdata_u  rd_word;
    hist_pkg::hist_rdata_u  rdata_q;

    // one read in flight at a time
    assign arready = !rd_busy;
    assign ar_hs   = arvalid && arready;

    // address and data taken together, none while a response is pending
    assign aw_hs   = awvalid && wvalid && !wr_pend && !bvalid;
    assign awready = aw_hs;
    assign wready  = aw_hs;

    // bit 0 of a control write frees the held bank
    assign rel_write = aw_hs && addr_is(awaddr, `HIST_ADDR_CONTROL) && wstrb[0] && wdata[0];

    // bin memory lookup the cycle after AR
    assign bin_off = ar_addr_q - BIN_BASE;
    assign rd_addr = bin_off[2 +: BIN_ADDR_BITS];
    assign rd_en   = rd_step1 && addr_is_bin(ar_addr_q);

    always_comb begin
        status             = '0;
        status.bank_ready  = bank_held;
        status.held_bank   = held_bank;
        status.stalled     = stalled;
        status.frame_count = frame_count;
    end

    // decode the data word by address
    always_comb begin
        rd_word = '0;
        if (addr_is(ar_addr_q, `HIST_ADDR_STATUS)) begin
            rd_word.status = status;
        end else if (addr_is_bin(ar_addr_q)) begin
            rd_word.bin.count = rd_count;
        end
    end

    assign rdata = rdata_q;

    // read channel, rvalid two edges after AR
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rd_busy  <= 1'b0;
            rd_step1 <= 1'b0;
            rd_step2 <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            rd_step1 <= ar_hs;
            rd_step2 <= rd_step1;
            if (ar_hs) begin
                rd_busy <= 1'b1;
            end else if (rvalid && rready) begin
                rd_busy <= 1'b0;
            end
            if (rd_step2) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // write channel, bvalid one edge after the handshake
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wr_pend <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            wr_pend <= aw_hs;
            if (wr_pend) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // read address, response data and write response
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            ar_addr_q <= araddr;
        end
        if (rd_step2) begin
            rdata_q <= rd_word;
            rresp   <= (addr_is(ar_addr_q, `HIST_ADDR_STATUS) || addr_is_bin(ar_addr_q)) ?
                       RESP_OKAY : RESP_SLVERR;
        end
        if (aw_hs) begin
            bresp <= addr_is(awaddr, `HIST_ADDR_CONTROL) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // bank ownership and frame counter
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bank_held   <= 1'b0;
            frame_count <= '0;
        end else if (done_pulse) begin
            bank_held   <= 1'b1;
            frame_count <= frame_count + 1'b1;
        end else if (rel_write) begin
            bank_held <= 1'b0;
        end
    end

    // responses wait for the master with their payload held
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!combin_res)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!combin_res)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// File: hdl/hist_bin_accumulator.sv
`include "hist_consts.svh"

module hist_bin_accumulator (
    input  logic                                       clk,
    input  logic                                       combin_res,
    input  logic                                       tag_valid,
    input  hist_pkg::hist_tagged_event_t               tag,
    output logic                                       tag_ready,
    input  logic                                       bank_held,
    output logic                                       done_pulse,
    output logic                                       held_bank,
    output logic                                       stalled,
    input  logic                                       rd_en,
    input  logic [`HIST_PIX_BITS+`HIST_BIN_BITS-1:0]   rd_addr,
    output logic [`HIST_COUNT_BITS-1:0]                rd_count
);

    localparam int ADDR_BITS = `HIST_PIX_BITS + `HIST_BIN_BITS;
    localparam int NUM_BINS  = 1 << ADDR_BITS;
    localparam int CNT_BITS  = `HIST_COUNT_BITS;
    localparam logic [CNT_BITS-1:0] CNT_MAX = '1;

    // two ping-pong banks, counts plus per-bin valid bits
    logic [CNT_BITS-1:0] mem [2][NUM_BINS];
    logic [NUM_BINS-1:0] bin_vld [2];

    // bank taking events
    logic                 active;

    // stage 1 reads, stage 2 writes
    logic                 s1_vld;
    logic                 s1_last;
    logic [ADDR_BITS-1:0] s1_addr;
    logic                 s2_vld;
    logic                 s2_last;
    logic [ADDR_BITS-1:0] s2_addr;
    logic [CNT_BITS-1:0]  s2_cnt;

    logic                 accept;
    logic                 swap_req;
    logic [CNT_BITS-1:0]  old_cnt;
    logic [CNT_BITS-1:0]  new_cnt;

    // no new frame enters while its last event is in flight or the swap waits
    assign tag_ready = !(s1_vld && s1_last) && !(s2_vld && s2_last) && !stalled;
    assign accept    = tag_valid && tag_ready;

    // swap on the cycle the last event writes, or later once the bank frees
    assign swap_req   = (s2_vld && s2_last) || stalled;
    assign done_pulse = swap_req && !bank_held;

    // read side, forward from the write stage on a back-to-back hit
    always_comb begin
        if (s2_vld && (s2_addr == s1_addr)) begin
            old_cnt = s2_cnt;
        end else if (bin_vld[active][s1_addr]) begin
            old_cnt = mem[active][s1_addr];
        end else begin
            // lazy clear, stale bin reads as empty
            old_cnt = '0;
        end
        new_cnt = (old_cnt == CNT_MAX) ? CNT_MAX : old_cnt + 1'b1;
    end

    // pipeline control and bank state
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            s1_vld     <= 1'b0;
            s1_last    <= 1'b0;
            s2_vld     <= 1'b0;
            s2_last    <= 1'b0;
            active     <= 1'b0;
            held_bank  <= 1'b0;
            stalled    <= 1'b0;
            bin_vld[0] <= '0;
            bin_vld[1] <= '0;
        end else begin
            s1_vld  <= accept;
            s1_last <= accept && tag.frame_last;
            s2_vld  <= s1_vld;
            s2_last <= s1_vld && s1_last;
            // stays set while readout keeps the other bank
            stalled <= swap_req && bank_held;
            if (s2_vld) begin
                bin_vld[active][s2_addr] <= 1'b1;
            end
            if (done_pulse) begin
                held_bank        <= active;
                active           <= !active;
                bin_vld[!active] <= '0;
            end
        end
    end

    // payload of the pipeline
    always_ff @(posedge clk) begin
        s1_addr <= {tag.pixel, tag.bin};
        s2_addr <= s1_addr;
        s2_cnt  <= new_cnt;
    end

    // bank write and readout port
    always_ff @(posedge clk) begin
        if (s2_vld) begin
            mem[active][s2_addr] <= s2_cnt;
        end
        if (rd_en) begin
            rd_count <= bin_vld[held_bank][rd_addr] ? mem[held_bank][rd_addr] : '0;
        end
    end

    // a stall backs up into the sequencer with the pipeline drained
    a_stall_blocks: assert property (@(posedge clk) disable iff (!combin_res)
        stalled |-> !tag_ready && !s1_vld && !s2_vld);

    // readout bank is never written while software holds it
    a_held_untouched: assert property (@(posedge clk) disable iff (!combin_res)
        s2_vld && bank_held |-> active != held_bank);

endmodule

// File: hdl/hist_consts.svh
`ifndef HIST_CONSTS_SVH
`define HIST_CONSTS_SVH

// bin index width, 16 bins per pixel
`define HIST_BIN_BITS 4

// sensor array size
`define HIST_PIXELS 4
`define HIST_PIX_BITS $clog2(`HIST_PIXELS)

// photons per pixel in one acquisition
`define HIST_EVENTS_PER_PIXEL 4

// acquisitions per frame
`define HIST_ACQS 3

// count width, saturates at all ones
`define HIST_COUNT_BITS 3

// AXI4-Lite address map, byte addresses
`define HIST_AXI_ADDR_BITS 12
`define HIST_ADDR_STATUS 12'h000
`define HIST_ADDR_CONTROL 12'h004
// bin (p, b) at base + 4 * (p * 16 + b)
`define HIST_ADDR_BIN_BASE 12'h100

`endif

// File: hdl/hist_event_sequencer.sv
`include "hist_consts.svh"

module hist_event_sequencer (
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         ev_valid,
    input  hist_pkg::hist_event_t        ev,
    output logic                         ev_ready,
    output logic                         tag_valid,
    output hist_pkg::hist_tagged_event_t tag,
    input  logic                         tag_ready
);

    localparam int EVT_BITS = (`HIST_EVENTS_PER_PIXEL > 1) ? $clog2(`HIST_EVENTS_PER_PIXEL) : 1;
    localparam int PIX_BITS = `HIST_PIX_BITS;
    localparam int ACQ_BITS = (`HIST_ACQS > 1) ? $clog2(`HIST_ACQS) : 1;

    logic                run;
    logic [EVT_BITS-1:0] evt_cnt;
    logic [PIX_BITS-1:0] pix_cnt;
    logic [ACQ_BITS-1:0] acq_cnt;
    logic                accept;
    logic                evt_wrap;
    logic                pix_wrap;
    logic                acq_wrap;

    // stage takes a new event when empty or draining this cycle
    assign ev_ready = run && (!tag_valid || tag_ready);
    assign accept   = ev_valid && ev_ready;

    assign evt_wrap = (evt_cnt == EVT_BITS'(`HIST_EVENTS_PER_PIXEL - 1));
    assign pix_wrap = (pix_cnt == PIX_BITS'(`HIST_PIXELS - 1));
    assign acq_wrap = (acq_cnt == ACQ_BITS'(`HIST_ACQS - 1));

    // run goes high on the first edge after release
    // nested counters, event inside pixel inside acquisition
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            run     <= 1'b0;
            evt_cnt <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
        end else begin
            run <= 1'b1;
            if (accept) begin
                if (!evt_wrap) begin
                    evt_cnt <= evt_cnt + 1'b1;
                end else begin
                    evt_cnt <= '0;
                    if (!pix_wrap) begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end else begin
                        pix_cnt <= '0;
                        acq_cnt <= acq_wrap ? '0 : acq_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // stage occupancy
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            tag_valid <= 1'b0;
        end else if (accept) begin
            tag_valid <= 1'b1;
        end else if (tag_ready) begin
            tag_valid <= 1'b0;
        end
    end

    // tag payload, loaded only on accept so it holds under stall
    always_ff @(posedge clk) begin
        if (accept) begin
            tag.bin        <= ev.bin;
            tag.pixel      <= pix_cnt;
            tag.frame_last <= evt_wrap && pix_wrap && acq_wrap;
        end
    end

    // held tag must not change until the accumulator takes it
    a_tag_stable: assert property (@(posedge clk) disable iff (!combin_res)
        tag_valid && !tag_ready |=> tag_valid && $stable(tag));

endmodule

// File: hdl/hist_pkg.sv
`include "hist_consts.svh"

package hist_pkg;

    // raw TDC event, bin index only
    typedef struct packed {
        logic [`HIST_BIN_BITS-1:0] bin;
    } hist_event_t;

    // event after the sequencer tagged it
    typedef struct packed {
        logic [`HIST_BIN_BITS-1:0] bin;
        logic [`HIST_PIX_BITS-1:0] pixel;
        // last event of last pixel of last acquisition
        logic                      frame_last;
    } hist_tagged_event_t;

    // status register layout
    typedef struct packed {
        logic [15:0] frame_count;
        logic [12:0] pad;
        logic        stalled;
        logic        held_bank;
        logic        bank_ready;
    } hist_status_t;

    // bin read view, count zero extended
    typedef struct packed {
        logic [31-`HIST_COUNT_BITS:0] zero;
        logic [`HIST_COUNT_BITS-1:0]  count;
    } hist_bin_word_t;

    // one read data word, decoded by address
    typedef union packed {
        hist_status_t   status;
        hist_bin_word_t bin;
    } hist_rdata_u;

endpackage

// File: hdl/hist_top.sv
`include "hist_consts.svh"

module hist_top (
    input  logic                           clk,
    input  logic                           combin_res,
    input  logic                           ev_valid,
    output logic                           ev_ready,
    input  hist_pkg::hist_event_t          ev,
    input  logic [`HIST_AXI_ADDR_BITS-1:0] awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [31:0]                    wdata,
    input  logic [3:0]                     wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [`HIST_AXI_ADDR_BITS-1:0] araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [31:0]                    rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready
);

    // tagged stream, sequencer to accumulator
    logic                         tag_valid;
    logic                         tag_ready;
    hist_pkg::hist_tagged_event_t tag;

    // bank handoff and readout port
    logic                                     bank_held;
    logic                                     done_pulse;
    logic                                     held_bank;
    logic                                     stalled;
    logic                                     rd_en;
    logic [`HIST_PIX_BITS+`HIST_BIN_BITS-1:0] rd_addr;
    logic [`HIST_COUNT_BITS-1:0]              rd_count;

    hist_event_sequencer seq_i (
        .clk        (clk),
        .combin_res (combin_res),
        .ev_valid   (ev_valid),
        .ev         (ev),
        .ev_ready   (ev_ready),
        .tag_valid  (tag_valid),
        .tag        (tag),
        .tag_ready  (tag_ready)
    );

    hist_bin_accumulator acc_i (
        .clk        (clk),
        .combin_res (combin_res),
        .tag_valid  (tag_valid),
        .tag        (tag),
        .tag_ready  (tag_ready),
        .bank_held  (bank_held),
        .done_pulse (done_pulse),
        .held_bank  (held_bank),
        .stalled    (stalled),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_count   (rd_count)
    );

    hist_axil_readout axil_i (
        .clk        (clk),
        .combin_res (combin_res),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .done_pulse (done_pulse),
        .held_bank  (held_bank),
        .stalled    (stalled),
        .bank_held  (bank_held),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_count   (rd_count)
    );

endmodule

// File: verification/hist_tb.sv
`include "hist_consts.svh"

module hist_tb;

    localparam int BIN_BITS     = `HIST_BIN_BITS;
    localparam int CNT_BITS     = `HIST_COUNT_BITS;
    localparam int ABITS        = `HIST_AXI_ADDR_BITS;
    localparam int PIXELS       = `HIST_PIXELS;
    localparam int BINS         = 1 << BIN_BITS;
    localparam int NUM_BINS     = PIXELS * BINS;
    localparam int EPP          = `HIST_EVENTS_PER_PIXEL;
    localparam int FRAME_EVENTS = `HIST_ACQS * PIXELS * EPP;
    localparam int POLL_LIMIT   = 40;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;
    localparam logic [ABITS-1:0] UNMAPPED = ABITS'('h080);
    // three frames plus one parked event, three bank scans plus polls and single reads
    localparam int NUM_EVENTS      = 3 * FRAME_EVENTS + 1;
    localparam int NUM_AXI         = 3 * NUM_BINS + 5 * POLL_LIMIT + 20;
    localparam int WATCHDOG_CYCLES = 16 + (NUM_EVENTS + NUM_AXI) * 20;

    typedef logic [BIN_BITS-1:0] bin_t;
    typedef logic [CNT_BITS-1:0] count_t;

    // counts stop at all ones
    localparam count_t SAT_MAX = '1;

    logic                  clk;
    logic                  combin_res;
    logic                  ev_valid;
    logic                  ev_ready;
    hist_pkg::hist_event_t ev;
    logic [ABITS-1:0]      awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [ABITS-1:0]      araddr;
    logic                  arvalid;
    logic                  arready;
    logic [31:0]           rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    integer seed = 19;
    int     value_errs;
    int     other_errs;
    // expected counts, indexed pixel * 16 + bin
    count_t model [NUM_BINS];
    // bins of one frame in arrival order
    bin_t   frame_bins [FRAME_EVENTS];

    hist_top hist_top_i (.*);

    always #50 clk = ~clk;

    task automatic report_mismatch(input string msg);
        value_errs++;
        $display("[FAIL] %0t %s", $time, msg);
    endtask

    task automatic check_status(input hist_pkg::hist_status_t got,
                                input hist_pkg::hist_status_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: status %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_count(input count_t got, input count_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: count %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: resp %b, expected %b", what, got, exp));
        end
    endtask

    function automatic hist_pkg::hist_status_t make_status(input logic ready, input logic held,
                                                          input logic stall, input int frames);
        hist_pkg::hist_status_t s;
        s             = '0;
        s.bank_ready  = ready;
        s.held_bank   = held;
        s.stalled     = stall;
        s.frame_count = 16'(frames);
        return s;
    endfunction

    function automatic logic [ABITS-1:0] bin_addr(input int pixel, input int bin);
        return ABITS'(`HIST_ADDR_BIN_BASE + 4 * (pixel * BINS + bin));
    endfunction

    // every bus task starts and ends 10 units after a rising edge
    task automatic axi_read(input logic [ABITS-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #10;
        rready = 1'b0;
    endtask

    task automatic axi_write(input logic [ABITS-1:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // awready only answers when both channels are valid
        @(negedge clk);
        while (!awready) begin
            @(negedge clk);
        end
        // both channels taken in the same cycle
        if (wready !== 1'b1) begin
            report_mismatch("wready low while awready high");
        end
        @(posedge clk);
        #10;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        resp = bresp;
        @(posedge clk);
        #10;
        bready = 1'b0;
    endtask

    task automatic read_status(output hist_pkg::hist_status_t st);
        logic [31:0] data;
        logic [1:0]  resp;
        hist_pkg::hist_rdata_u word;
        axi_read(`HIST_ADDR_STATUS, data, resp);
        word = data;
        st   = word.status;
        check_resp(resp, OKAY, "status read");
    endtask

    // poll until bank_ready, or stalled when asked
    task automatic wait_status(input logic want_stall, output hist_pkg::hist_status_t st);
        logic flag;
        int   polls;
        flag  = 1'b0;
        polls = 0;
        while (!flag && polls < POLL_LIMIT) begin
            read_status(st);
            flag = want_stall ? st.stalled : st.bank_ready;
            polls++;
        end
        if (!flag) begin
            other_errs++;
            $display("status %s flag still clear after %0d polls",
                     want_stall ? "stall" : "bank ready", polls);
        end
    endtask

    task automatic sample_ev_ready(output logic rdy);
        @(negedge clk);
        rdy = ev_ready;
        @(posedge clk);
        #10;
    endtask

    // valid stays up until the handshake edge
    task automatic send_event(input bin_t bin);
        ev_valid = 1'b1;
        ev.bin   = bin;
        @(negedge clk);
        while (!ev_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        ev_valid = 1'b0;
    endtask

    task automatic send_frame(input logic gaps);
        int idle;
        for (int k = 0; k < FRAME_EVENTS; k++) begin
            idle = gaps ? int'($unsigned($random(seed)) % 3) : 0;
            repeat (idle) begin
                @(posedge clk);
                #10;
            end
            send_event(frame_bins[k]);
        end
    endtask

    // arrival order is acquisition, then pixel, then event
    task automatic fill_frame(input int kind);
        int evt;
        int pix;
        int acq;
        for (int k = 0; k < FRAME_EVENTS; k++) begin
            evt = k % EPP;
            pix = (k / EPP) % PIXELS;
            acq = k / (EPP * PIXELS);
            case (kind)
                // pixel 0 hammers bin 5, twelve hits
                1: frame_bins[k] = (pix == 0) ? bin_t'(5) : bin_t'((pix * 3 + evt * 2 + acq) % BINS);
                2: frame_bins[k] = bin_t'((pix * 5 + evt + acq * 4 + 7) % BINS);
                default: frame_bins[k] = bin_t'($unsigned($random(seed)) % BINS);
            endcase
        end
    endtask

    // fresh bank per frame, saturating increment
    task automatic build_model();
        int idx;
        for (int i = 0; i < NUM_BINS; i++) begin
            model[i] = '0;
        end
        for (int k = 0; k < FRAME_EVENTS; k++) begin
            idx = ((k / EPP) % PIXELS) * BINS + int'(frame_bins[k]);
            if (model[idx] != SAT_MAX) begin
                model[idx] = model[idx] + 1'b1;
            end
        end
    endtask

    task automatic check_bank(input string what);
        logic [31:0] data;
        logic [1:0]  resp;
        hist_pkg::hist_rdata_u word;
        for (int p = 0; p < PIXELS; p++) begin
            for (int b = 0; b < BINS; b++) begin
                axi_read(bin_addr(p, b), data, resp);
                word = data;
                check_resp(resp, OKAY, $sformatf("%s bin %0d/%0d", what, p, b));
                check_count(word.bin.count, model[p * BINS + b],
                            $sformatf("%s bin %0d/%0d", what, p, b));
                if (word.bin.zero != '0) begin
                    report_mismatch($sformatf("%s bin %0d/%0d upper bits set", what, p, b));
                end
            end
        end
    endtask

    task automatic test_after_reset();
        hist_pkg::hist_status_t st;
        hist_pkg::hist_rdata_u  word;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        rdy;
        read_status(st);
        check_status(st, make_status(1'b0, 1'b0, 1'b0, 0), "status after reset");
        sample_ev_ready(rdy);
        if (rdy !== 1'b1) begin
            report_mismatch("ev_ready low after reset");
        end
        axi_read(UNMAPPED, data, resp);
        word = data;
        check_resp(resp, SLVERR, "unmapped read");
        check_status(word.status, '0, "unmapped read data");
    endtask

    task automatic test_one_frame();
        hist_pkg::hist_status_t st;
        hist_pkg::hist_rdata_u  word;
        logic [31:0] data;
        logic [1:0]  resp;
        fill_frame(1);
        build_model();
        send_frame(1'b1);
        wait_status(1'b0, st);
        check_status(st, make_status(1'b1, 1'b0, 1'b0, 1), "frame 1 status");
        axi_read(bin_addr(0, 5), data, resp);
        word = data;
        check_count(word.bin.count, SAT_MAX, "saturated bin");
        check_bank("frame 1");
    endtask

    task automatic test_lazy_clear();
        hist_pkg::hist_status_t st;
        logic [1:0] resp;
        axi_write(`HIST_ADDR_CONTROL, 32'h1, resp);
        check_resp(resp, OKAY, "release after frame 1");
        fill_frame(2);
        build_model();
        send_frame(1'b0);
        wait_status(1'b0, st);
        check_status(st, make_status(1'b1, 1'b1, 1'b0, 2), "frame 2 status");
        check_bank("frame 2");
    endtask

    // frame 3 lands in bank 0, so stale frame 1 counts would show here
    task automatic test_back_pressure();
        hist_pkg::hist_status_t st;
        logic [1:0] resp;
        logic       rdy;
        int         waits;
        fill_frame(3);
        build_model();
        send_frame(1'b1);
        // next frame's first event parks in the sequencer
        send_event('0);
        wait_status(1'b1, st);
        check_status(st, make_status(1'b1, 1'b1, 1'b1, 2), "stalled status");
        sample_ev_ready(rdy);
        if (rdy !== 1'b0) begin
            report_mismatch("ev_ready high during stall");
        end
        axi_write(`HIST_ADDR_CONTROL, 32'h1, resp);
        check_resp(resp, OKAY, "release after frame 2");
        wait_status(1'b0, st);
        check_status(st, make_status(1'b1, 1'b0, 1'b0, 3), "frame 3 status");
        rdy   = 1'b0;
        waits = 0;
        while (!rdy && waits < 20) begin
            sample_ev_ready(rdy);
            waits++;
        end
        if (!rdy) begin
            other_errs++;
            $display("event stream stayed blocked after the bank release");
        end
        check_bank("frame 3");
    endtask

    task automatic test_write_resp();
        hist_pkg::hist_status_t st;
        hist_pkg::hist_rdata_u  word;
        logic [31:0] data;
        logic [1:0]  resp;
        // bit 0 clear, nothing released
        axi_write(`HIST_ADDR_CONTROL, 32'h0, resp);
        check_resp(resp, OKAY, "control write");
        axi_write(`HIST_ADDR_STATUS, 32'hffff_ffff, resp);
        check_resp(resp, SLVERR, "status write");
        axi_write(bin_addr(0, 0), 32'h7, resp);
        check_resp(resp, SLVERR, "bin write");
        read_status(st);
        check_status(st, make_status(1'b1, 1'b0, 1'b0, 3), "status after writes");
        axi_read(bin_addr(0, 0), data, resp);
        word = data;
        check_count(word.bin.count, model[0], "bin 0/0 after write");
    endtask

    initial begin
        clk        = 1'b0;
        combin_res = 1'b0;
        ev_valid   = 1'b0;
        ev         = '0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        value_errs = 0;
        other_errs = 0;
        repeat (16) @(posedge clk);
        #10;
        combin_res = 1'b1;
        test_after_reset();
        test_one_frame();
        test_lazy_clear();
        test_back_pressure();
        test_write_resp();
        $display("summary: %0d mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // bound from event and bus access counts
    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("summary: %0d mismatches, %0d other failures", value_errs, other_errs + 1);
        $display("Errors found");
        $finish;
    end

endmodule
